//--- include/exe_cfg.svh
/*
 * execute stage configuration
 *   data width
 *   multiply occupancy in cycles
 *   divide occupancy in cycles (iterations plus fix-up)
 */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath width
`define EXE_XLEN 32

// cycles the multiply/divide unit stays busy per operation
`define EXE_MUL_CYCLES 2
`define EXE_DIV_CYCLES 33   // 32 restoring steps + sign fix-up

`endif

//--- hw/exePkg.sv
/*
 * execute stage types
 *   ALU opcodes, branch, load/store and exception encodings
 *   writeback, read-back and destination selects
 *   ID/EXE and EXE/MEM bundles, branch result
 */
`include "exe_cfg.svh"

package exePkg;
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO, OP_NOP
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_JUMP
    } branchTypeT;

    typedef enum logic [2:0] {LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW} loadTypeT;
    typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} storeTypeT;

    // earlier in the list means raised earlier, so higher priority
    typedef enum logic [3:0] {
        EXC_NONE, EXC_INTERRUPT, EXC_FETCH_ADDR, EXC_RESERVED, EXC_SYSCALL,
        EXC_BREAK, EXC_OVERFLOW, EXC_LOAD_ADDR, EXC_STORE_ADDR
    } exceptT;

    typedef struct packed {
        logic gprWr;
        logic hiWr;
        logic loWr;
    } regsWrT;

    typedef enum logic [1:0] {WB_PC8, WB_ALU, WB_OUTB} wbSelT;
    typedef enum logic [1:0] {RS_BUSB, RS_HI, RS_LO} readSelT;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} dstSelT;

    typedef struct packed {
        logic                 valid;
        logic [`EXE_XLEN-1:0] pc;
        logic [`EXE_XLEN-1:0] busA;
        logic [`EXE_XLEN-1:0] busB;
        logic [`EXE_XLEN-1:0] imm32;
        logic [4:0]           rt;
        logic [4:0]           rd;
        logic [4:0]           shamt;
        aluOpT                aluOp;
        logic                 srcShamt;   // operand A from shamt
        logic                 srcImm;     // operand B from imm32
        dstSelT               dstSel;
        wbSelT                wbSel;
        readSelT              readSel;
        branchTypeT           branchType;
        logic                 predTaken;  // fetch prediction
        logic [`EXE_XLEN-1:0] branchAddr;
        logic [`EXE_XLEN-1:0] jumpAddr;
        loadTypeT             loadType;
        storeTypeT            storeType;
        regsWrT               regsWr;
        exceptT               exceptIn;
    } idExeT;

    typedef struct packed {
        logic                 valid;
        logic [`EXE_XLEN-1:0] pc;
        logic [`EXE_XLEN-1:0] aluOut;
        logic [`EXE_XLEN-1:0] outB;
        logic [`EXE_XLEN-1:0] result;
        logic [4:0]           dst;
        loadTypeT             loadType;
        storeTypeT            storeType;
        regsWrT               regsWr;
        exceptT               except;
    } exeMemT;

    typedef struct packed {
        logic                 mispredict;
        logic                 taken;
        logic [`EXE_XLEN-1:0] correction;
    } bResultT;
endpackage

//--- hw/exeReg.sv
/*
 * ID/EXE pipeline register
 *   write enable, priority flush, valid tracking
 */
`timescale 1ns/1ns

module exeReg (
    input  logic          clk,
    input  logic          rstN,
    input  logic          exeWr,
    input  logic          exeFlush,
    input  exePkg::idExeT id,
    output exePkg::idExeT cur
);

    // flush beats write, whole bundle cleared so valid drops too
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cur <= '0;
        end else if (exeFlush) begin
            cur <= '0;
        end else if (exeWr) begin
            cur <= id;
        end
    end

    // downstream gating relies on a clean valid bit once out of reset
    validKnown: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown(cur.valid)
    ) else $error("exeReg: cur.valid unknown");

endmodule

//--- hw/alu.sv
/*
 * execute stage ALU
 *   operand selection (shamt / immediate)
 *   arithmetic, logic, compare, shift, LUI
 *   signed overflow for ADD and SUB
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module alu (
    input  exePkg::idExeT        cur,
    output logic [`EXE_XLEN-1:0] aluOut,
    output logic                 overflow
);
    import exePkg::*;

    localparam int W = `EXE_XLEN;

    logic [W-1:0] opA;
    logic [W-1:0] opB;
    logic [W-1:0] sum;
    logic [W-1:0] diff;

    assign opA  = cur.srcShamt ? {{(W-5){1'b0}}, cur.shamt} : cur.busA;
    assign opB  = cur.srcImm ? cur.imm32 : cur.busB;
    assign sum  = opA + opB;
    assign diff = opA - opB;

    always_comb begin
        aluOut   = '0;   // mult/div, MT and NOP leave zero
        overflow = 1'b0;
        case (cur.aluOp)
            OP_ADD: begin
                aluOut   = sum;
                overflow = (opA[W-1] == opB[W-1]) && (sum[W-1] != opA[W-1]);
            end
            OP_ADDU: aluOut = sum;
            OP_SUB: begin
                aluOut   = diff;
                overflow = (opA[W-1] != opB[W-1]) && (diff[W-1] != opA[W-1]);
            end
            OP_SUBU: aluOut = diff;
            OP_AND:  aluOut = opA & opB;
            OP_OR:   aluOut = opA | opB;
            OP_XOR:  aluOut = opA ^ opB;
            OP_NOR:  aluOut = ~(opA | opB);
            OP_SLT:  aluOut = {{(W-1){1'b0}}, $signed(opA) < $signed(opB)};
            OP_SLTU: aluOut = {{(W-1){1'b0}}, opA < opB};
            // shifts move B by the low bits of A
            OP_SLL:  aluOut = opB << opA[4:0];
            OP_SRL:  aluOut = opB >> opA[4:0];
            OP_SRA:  aluOut = $signed(opB) >>> opA[4:0];
            OP_LUI:  aluOut = {opB[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

endmodule

//--- hw/branchSolve.sv
/*
 * branch resolution
 *   condition evaluation per branch type
 *   misprediction against the fetch prediction
 *   correction vector
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module branchSolve (
    input  exePkg::idExeT   cur,
    input  logic            exeWr,
    output exePkg::bResultT bResult
);
    import exePkg::*;

    logic taken;
    logic aZero;
    logic aNeg;

    assign aZero = (cur.busA == '0);
    assign aNeg  = cur.busA[`EXE_XLEN-1];

    always_comb begin
        case (cur.branchType)
            BR_BEQ:  taken = (cur.busA == cur.busB);
            BR_BNE:  taken = (cur.busA != cur.busB);
            BR_BGEZ: taken = !aNeg;
            BR_BGTZ: taken = !aNeg && !aZero;
            BR_BLEZ: taken = aNeg || aZero;
            BR_BLTZ: taken = aNeg;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // only redirect once the stage actually advances
    assign bResult.mispredict = cur.valid && exeWr && (taken != cur.predTaken);
    assign bResult.taken      = taken;
    assign bResult.correction = (cur.branchType == BR_JUMP) ? cur.jumpAddr :
                                taken                       ? cur.branchAddr :
                                                              cur.pc + `EXE_XLEN'(8);

endmodule

//--- hw/multDiv.sv
/*
 * multi-cycle multiply/divide unit
 *   busy counter, stall and finish pulse, abort on flush
 *   signed ops run on magnitudes, signs fixed on finish
 *   restoring divider, one quotient bit per cycle
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module multDiv (
    input  logic                 clk,
    input  logic                 rstN,
    input  exePkg::idExeT        cur,
    input  logic                 exeFlush,
    output logic                 mdStall,
    output logic                 finish,
    output logic [`EXE_XLEN-1:0] hiRes,
    output logic [`EXE_XLEN-1:0] loRes
);
    import exePkg::*;

    localparam int W = `EXE_XLEN;

    logic         busy;
    logic [5:0]   cnt;
    logic [5:0]   lastCnt;
    logic         isDiv;
    logic         negQ;      // quotient / product sign
    logic         negR;      // remainder follows dividend
    logic         divZero;
    logic [W-1:0] rem;
    logic [W-1:0] quo;
    logic [W-1:0] divisor;

    logic           mdOp;
    logic           signedOp;
    logic           divOp;
    logic           startNow;
    logic           finishRaw;
    logic [W-1:0]   magA;
    logic [W-1:0]   magB;
    logic [2*W-1:0] prodMag;
    logic [2*W-1:0] prodRes;
    logic [W:0]     shifted;
    logic [W:0]     trial;

    assign mdOp     = cur.valid && (cur.aluOp inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU});
    assign signedOp = (cur.aluOp == OP_MULT) || (cur.aluOp == OP_DIV);
    assign divOp    = (cur.aluOp == OP_DIV) || (cur.aluOp == OP_DIVU);
    assign magA     = (signedOp && cur.busA[W-1]) ? -cur.busA : cur.busA;
    assign magB     = (signedOp && cur.busB[W-1]) ? -cur.busB : cur.busB;
    assign prodMag  = {{W{1'b0}}, magA} * {{W{1'b0}}, magB};

    // upstream must advance on finish or the same op restarts
    assign startNow  = mdOp && !busy;
    assign finishRaw = busy && (cnt == lastCnt);
    assign finish    = finishRaw && !exeFlush;
    assign mdStall   = startNow || (busy && !finishRaw);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (exeFlush) begin
            busy <= 1'b0;   // abort without a finish
            cnt  <= '0;
        end else if (startNow) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (finishRaw) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 6'd1;
        end
    end

    // one restoring step shifts in the next dividend bit and tries the subtract
    assign shifted = {rem, quo[W-1]};
    assign trial   = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (startNow) begin
            isDiv   <= divOp;
            negQ    <= signedOp && (cur.busA[W-1] ^ cur.busB[W-1]);
            negR    <= signedOp && cur.busA[W-1];
            divZero <= (cur.busB == '0);
            divisor <= magB;
            lastCnt <= divOp ? 6'(`EXE_DIV_CYCLES - 1) : 6'(`EXE_MUL_CYCLES - 1);
            if (divOp) begin
                rem <= '0;
                quo <= magA;
            end else begin
                {rem, quo} <= prodMag;
            end
        end else if (busy && isDiv && (cnt < 6'(`EXE_DIV_CYCLES - 1))) begin
            if (!trial[W]) begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end else begin
                rem <= shifted[W-1:0];
                quo <= {quo[W-2:0], 1'b0};
            end
        end
    end

    assign prodRes = negQ ? -{rem, quo} : {rem, quo};

    always_comb begin
        if (isDiv) begin
            hiRes = negR ? -rem : rem;
            loRes = divZero ? '1 : (negQ ? -quo : quo);   // x/0 gives all ones
        end else begin
            hiRes = prodRes[2*W-1:W];
            loRes = prodRes[W-1:0];
        end
    end

    // a finish closes an op that was already running a cycle earlier
    finishAfterBusy: assert property (
        @(posedge clk) disable iff (!rstN) finish |-> $past(busy)
    ) else $error("multDiv: finish without a running operation");

    // upstream holds the stage register for the whole operation
    curHeldWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN) busy |-> $stable(cur)
    ) else $error("multDiv: stage register changed under a running operation");

endmodule

//--- hw/hiLo.sv
/*
 * HI and LO registers
 *   unit result on finish, else MTHI/MTLO data
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module hiLo (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 finish,
    input  exePkg::regsWrT       regsWr,
    input  logic [`EXE_XLEN-1:0] busA,
    input  logic [`EXE_XLEN-1:0] hiRes,
    input  logic [`EXE_XLEN-1:0] loRes,
    output logic [`EXE_XLEN-1:0] hi,
    output logic [`EXE_XLEN-1:0] lo
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (finish) begin
            hi <= hiRes;
            lo <= loRes;
        end else begin
            if (regsWr.hiWr) hi <= busA;   // MTHI
            if (regsWr.loWr) lo <= busA;   // MTLO
        end
    end

endmodule

//--- hw/exceptInExe.sv
/*
 * execute stage exception merge
 *   incoming exception, overflow, load/store misalignment
 */
`timescale 1ns/1ns

module exceptInExe (
    input  exePkg::idExeT  cur,
    input  logic           overflow,
    input  logic [1:0]     addrLow,
    output exePkg::exceptT except
);
    import exePkg::*;

    logic loadMis;
    logic storeMis;

    // word needs both low bits clear, halfword only bit 0
    assign loadMis = ((cur.loadType == LD_LW) && (addrLow != 2'b00)) ||
                     ((cur.loadType inside {LD_LH, LD_LHU}) && addrLow[0]);
    assign storeMis = ((cur.storeType == ST_SW) && (addrLow != 2'b00)) ||
                      ((cur.storeType == ST_SH) && addrLow[0]);

    always_comb begin
        if (cur.exceptIn != EXC_NONE) except = cur.exceptIn;   // earlier stage wins
        else if (overflow)            except = EXC_OVERFLOW;
        else if (loadMis)             except = EXC_LOAD_ADDR;
        else if (storeMis)            except = EXC_STORE_ADDR;
        else                          except = EXC_NONE;
    end

endmodule

//--- hw/topExe.sv
/*
 * execute stage top
 *   stage register, ALU, branch, mult/div, HI/LO, exceptions
 *   outB, result and destination muxes
 *   side-effect suppression under exeDisWr
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module topExe (
    input  logic            clk,
    input  logic            rstN,
    input  logic            exeWr,
    input  logic            exeFlush,
    input  logic            exeDisWr,
    input  exePkg::idExeT   id,
    output exePkg::exeMemT  exeMem,
    output exePkg::bResultT bResult,
    output logic            mdStall
);
    import exePkg::*;

    idExeT                cur;
    logic [`EXE_XLEN-1:0] aluOut;
    logic [`EXE_XLEN-1:0] hiRes;
    logic [`EXE_XLEN-1:0] loRes;
    logic [`EXE_XLEN-1:0] hi;
    logic [`EXE_XLEN-1:0] lo;
    logic [`EXE_XLEN-1:0] outB;
    logic                 overflow;
    logic                 mdFinish;
    logic                 finalFinish;
    regsWrT               finalWr;
    regsWrT               hiLoWr;
    exceptT               exceptOut;

    exeReg uExeReg (.clk(clk), .rstN(rstN), .exeWr(exeWr), .exeFlush(exeFlush),
                    .id(id), .cur(cur));

    alu uAlu (.cur(cur), .aluOut(aluOut), .overflow(overflow));

    branchSolve uBranchSolve (.cur(cur), .exeWr(exeWr), .bResult(bResult));

    multDiv uMultDiv (.clk(clk), .rstN(rstN), .cur(cur), .exeFlush(exeFlush),
                      .mdStall(mdStall), .finish(mdFinish), .hiRes(hiRes), .loRes(loRes));

    // suppressed or empty slots leave no side effects
    assign finalWr     = (exeDisWr || !cur.valid) ? '0 : cur.regsWr;
    assign finalFinish = mdFinish && !exeDisWr && cur.valid;
    assign hiLoWr      = mdStall ? '0 : finalWr;   // no MT writes while the unit runs

    hiLo uHiLo (.clk(clk), .rstN(rstN), .finish(finalFinish), .regsWr(hiLoWr),
                .busA(cur.busA), .hiRes(hiRes), .loRes(loRes), .hi(hi), .lo(lo));

    exceptInExe uExceptInExe (.cur(cur), .overflow(overflow), .addrLow(aluOut[1:0]),
                              .except(exceptOut));

    always_comb begin
        case (cur.readSel)
            RS_HI:   outB = hi;   // MFHI
            RS_LO:   outB = lo;   // MFLO
            default: outB = cur.busB;
        endcase
    end

    always_comb begin
        exeMem.valid  = cur.valid;
        exeMem.pc     = cur.pc;
        exeMem.aluOut = aluOut;
        exeMem.outB   = outB;
        case (cur.wbSel)
            WB_PC8:  exeMem.result = cur.pc + `EXE_XLEN'(8);   // link address
            WB_OUTB: exeMem.result = outB;
            default: exeMem.result = aluOut;
        endcase
        case (cur.dstSel)
            DST_RT:  exeMem.dst = cur.rt;
            DST_RA:  exeMem.dst = 5'd31;
            default: exeMem.dst = cur.rd;
        endcase
        exeMem.loadType  = exeDisWr ? LD_NONE : cur.loadType;
        exeMem.storeType = exeDisWr ? ST_NONE : cur.storeType;
        exeMem.regsWr    = finalWr;
        exeMem.except    = exceptOut;
    end

endmodule

//--- verif/tbTopExe.sv
/*
 * testbench for the execute stage
 *   clock, reset, cycle limit
 *   reference model for ALU, branch, mult/div and HI/LO
 *   compare tasks and directed / random stimulus
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module tbTopExe;
    import exePkg::*;

    localparam int MaxCycles = 8000;   // ~200 instructions of up to 34 cycles plus reset

    logic        clk = 1'b0;
    logic        rstN;
    logic        exeWr;
    logic        exeFlush;
    logic        exeDisWr;
    idExeT       id;
    exeMemT      exeMem;
    bResultT     bResult;
    logic        mdStall;

    integer      seed = 32'h8b87_9d9f;
    int          cycles = 0;
    logic [31:0] refHi;
    logic [31:0] refLo;
    logic        doCheck;
    exeMemT      expMem;
    bResultT     expBr;

    topExe u_dut (.clk(clk), .rstN(rstN), .exeWr(exeWr), .exeFlush(exeFlush),
                  .exeDisWr(exeDisWr), .id(id), .exeMem(exeMem), .bResult(bResult),
                  .mdStall(mdStall));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Test failed");
            $fatal(1, "simulation ran past %0d cycles without finishing", MaxCycles);
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic reportMismatch(string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "mismatch");
    endtask

    task automatic checkExeMem(exeMemT got, exeMemT exp);
        if (got !== exp)
            reportMismatch($sformatf("exeMem got %h expected %h", got, exp));
    endtask

    task automatic checkBResult(bResultT got, bResultT exp);
        if (got !== exp)
            reportMismatch($sformatf("bResult got %h expected %h", got, exp));
    endtask

    task automatic checkWord(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            reportMismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // {overflow, value}
    function automatic logic [32:0] refAlu(idExeT b);
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] v;
        logic        ovf;
        longint      s;
        a = b.srcShamt ? {27'd0, b.shamt} : b.busA;
        c = b.srcImm ? b.imm32 : b.busB;
        v = '0;
        ovf = 1'b0;
        case (b.aluOp)
            OP_ADD, OP_SUB: begin
                if (b.aluOp == OP_ADD) s = longint'($signed(a)) + longint'($signed(c));
                else s = longint'($signed(a)) - longint'($signed(c));
                v = s[31:0];
                ovf = (s != longint'($signed(v)));   // does not fit in 32 bits
            end
            OP_ADDU: v = a + c;
            OP_SUBU: v = a - c;
            OP_AND:  v = a & c;
            OP_OR:   v = a | c;
            OP_XOR:  v = a ^ c;
            OP_NOR:  v = ~(a | c);
            OP_SLT:  v = {31'd0, $signed(a) < $signed(c)};
            OP_SLTU: v = {31'd0, a < c};
            OP_SLL:  v = c << a[4:0];
            OP_SRL:  v = c >> a[4:0];
            OP_SRA:  v = $signed(c) >>> a[4:0];
            OP_LUI:  v = {c[15:0], 16'h0000};
            default: v = '0;
        endcase
        return {ovf, v};
    endfunction

    function automatic exeMemT refExe(idExeT b, logic dis);
        exeMemT      e;
        logic [32:0] r;
        logic        ldMis;
        logic        stMis;
        r = refAlu(b);
        e.valid = b.valid;
        e.pc = b.pc;
        e.aluOut = r[31:0];
        e.outB = (b.readSel == RS_HI) ? refHi : (b.readSel == RS_LO) ? refLo : b.busB;
        e.result = (b.wbSel == WB_PC8) ? b.pc + 32'd8 : (b.wbSel == WB_OUTB) ? e.outB : r[31:0];
        e.dst = (b.dstSel == DST_RT) ? b.rt : (b.dstSel == DST_RA) ? 5'd31 : b.rd;
        e.loadType = dis ? LD_NONE : b.loadType;
        e.storeType = dis ? ST_NONE : b.storeType;
        e.regsWr = (dis || !b.valid) ? '0 : b.regsWr;
        ldMis = (b.loadType == LD_LW && r[1:0] != 2'b00) ||
                ((b.loadType == LD_LH || b.loadType == LD_LHU) && r[0]);
        stMis = (b.storeType == ST_SW && r[1:0] != 2'b00) || (b.storeType == ST_SH && r[0]);
        if (b.exceptIn != EXC_NONE) e.except = b.exceptIn;
        else if (r[32])             e.except = EXC_OVERFLOW;
        else if (ldMis)             e.except = EXC_LOAD_ADDR;
        else if (stMis)             e.except = EXC_STORE_ADDR;
        else                        e.except = EXC_NONE;
        return e;
    endfunction

    function automatic bResultT refBranch(idExeT b, logic wr);
        bResultT r;
        logic    t;
        case (b.branchType)
            BR_BEQ:  t = (b.busA == b.busB);
            BR_BNE:  t = (b.busA != b.busB);
            BR_BGEZ: t = ($signed(b.busA) >= 0);
            BR_BGTZ: t = ($signed(b.busA) > 0);
            BR_BLEZ: t = ($signed(b.busA) <= 0);
            BR_BLTZ: t = ($signed(b.busA) < 0);
            BR_JUMP: t = 1'b1;
            default: t = 1'b0;
        endcase
        r.taken = t;
        r.mispredict = b.valid && wr && (t != b.predTaken);
        if (b.branchType == BR_JUMP) r.correction = b.jumpAddr;
        else if (t)                  r.correction = b.branchAddr;
        else                         r.correction = b.pc + 32'd8;
        return r;
    endfunction

    task automatic updateMulDiv(idExeT b);
        longint      sa;
        longint      sb;
        longint      q;
        longint      rm;
        logic [63:0] p;
        sa = longint'($signed(b.busA));
        sb = longint'($signed(b.busB));
        p = '0;
        case (b.aluOp)
            OP_MULT:  p = sa * sb;
            OP_MULTU: p = {32'd0, b.busA} * {32'd0, b.busB};
            default: begin
                if (b.busB == '0) begin
                    p = {b.busA, 32'hffff_ffff};   // x/0
                end else if (b.aluOp == OP_DIV) begin
                    q = sa / sb;
                    rm = sa % sb;
                    p = {rm[31:0], q[31:0]};
                end else begin
                    p = {b.busA % b.busB, b.busA / b.busB};
                end
            end
        endcase
        refHi = p[63:32];
        refLo = p[31:0];
    endtask

    always @(negedge clk) begin
        if (doCheck) begin
            checkExeMem(exeMem, expMem);
            checkBResult(bResult, expBr);
        end
    end

    function automatic idExeT makeBase();
        idExeT       b;
        logic [31:0] r;
        b = '0;
        r = rnd();
        b.valid = 1'b1;
        b.pc = {r[31:2], 2'b00};
        b.busA = rnd();
        b.busB = rnd();
        b.imm32 = rnd();
        r = rnd();
        b.rt = r[4:0];
        b.rd = r[9:5];
        b.shamt = r[14:10];
        b.aluOp = OP_NOP;
        b.wbSel = WB_ALU;
        return b;
    endfunction

    task automatic runInstr(idExeT b, logic dis);
        logic isMd;
        int   n;
        int   k;
        isMd = b.aluOp inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
        n = (b.aluOp inside {OP_DIV, OP_DIVU}) ? `EXE_DIV_CYCLES : `EXE_MUL_CYCLES;
        @(posedge clk);
        doCheck = 1'b0;
        id <= b;
        exeWr <= 1'b1;
        @(posedge clk);   // bundle now in the stage
        expMem = refExe(b, dis);
        expBr = refBranch(b, !isMd);
        doCheck = 1'b1;
        id <= '0;
        exeWr <= !isMd;   // hold upstream while the unit runs
        exeDisWr <= dis;
        if (!dis && b.regsWr.hiWr) refHi = b.busA;
        if (!dis && b.regsWr.loWr) refLo = b.busA;
        if (isMd) begin
            for (k = 0; k < n; k++) begin
                @(negedge clk);
                if (mdStall !== 1'b1)
                    reportMismatch($sformatf("mdStall low in busy cycle %0d of %0d", k, n));
                @(posedge clk);
            end
            exeWr <= 1'b1;   // stage moves on in the finish cycle
            @(negedge clk);
            if (mdStall !== 1'b0)
                reportMismatch("mdStall still high in finish cycle");
            if (!dis) updateMulDiv(b);
        end
    endtask

    task automatic readBack();
        idExeT b;
        b = makeBase();
        b.wbSel = WB_OUTB;
        b.regsWr.gprWr = 1'b1;
        b.readSel = RS_HI;
        runInstr(b, 1'b0);
        @(negedge clk);
        checkWord("HI via MFHI", exeMem.result, refHi);
        b.readSel = RS_LO;
        runInstr(b, 1'b0);
        @(negedge clk);
        checkWord("LO via MFLO", exeMem.result, refLo);
    endtask

    task automatic flushDivide(idExeT b);
        @(posedge clk);
        doCheck = 1'b0;
        id <= b;
        exeWr <= 1'b1;
        exeDisWr <= 1'b0;
        @(posedge clk);
        id <= '0;
        exeWr <= 1'b0;
        repeat (5) @(posedge clk);
        exeFlush <= 1'b1;
        @(posedge clk);
        exeFlush <= 1'b0;
        exeWr <= 1'b1;
        @(negedge clk);
        if (mdStall !== 1'b0 || exeMem.valid !== 1'b0)
            reportMismatch("flush did not abort the divide");
    endtask

    initial begin
        idExeT       b;
        logic [31:0] r;
        rstN <= 1'b0;
        exeWr <= 1'b0;
        exeFlush <= 1'b0;
        exeDisWr <= 1'b0;
        id <= '0;
        doCheck = 1'b0;
        refHi = '0;
        refLo = '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // random ALU ops with some pushed toward overflow
        for (int i = 0; i < 60; i++) begin
            b = makeBase();
            r = rnd();
            b.aluOp = aluOpT'(5'(r % 32'd14));
            b.srcImm = r[8];
            b.srcShamt = r[9] && (b.aluOp inside {OP_SLL, OP_SRL, OP_SRA});
            b.dstSel = dstSelT'(2'(r[15:12] % 4'd3));
            b.regsWr.gprWr = 1'b1;
            if (r[10]) b.busA = r[11] ? 32'h7fff_ffff : 32'h8000_0000;
            runInstr(b, 1'b0);
        end

        for (int i = 0; i < 40; i++) begin
            b = makeBase();
            r = rnd();
            b.branchType = branchTypeT'(3'(1 + r % 32'd7));
            b.predTaken = r[7];
            if (r[8]) b.busB = b.busA;
            if (r[9]) b.busA = '0;
            b.branchAddr = rnd();
            b.jumpAddr = rnd();
            b.wbSel = WB_PC8;
            b.dstSel = DST_RA;
            runInstr(b, 1'b0);
        end

        // mult/div with a zero divisor in the last four
        for (int i = 0; i < 12; i++) begin
            b = makeBase();
            b.aluOp = aluOpT'(5'(14 + i % 4));
            if (i >= 8) b.busB = '0;
            runInstr(b, 1'b0);
            readBack();
        end

        for (int i = 0; i < 10; i++) begin
            b = makeBase();
            b.aluOp = OP_MTHI;
            b.regsWr.hiWr = 1'b1;
            runInstr(b, 1'b0);
            b = makeBase();
            b.aluOp = OP_MTLO;
            b.regsWr.loWr = 1'b1;
            runInstr(b, 1'b0);
            readBack();
        end

        // loads and stores at busA + imm32
        for (int i = 0; i < 40; i++) begin
            b = makeBase();
            r = rnd();
            b.aluOp = OP_ADDU;
            b.srcImm = 1'b1;
            if (r[0]) begin
                b.loadType = loadTypeT'(3'(1 + r[7:4] % 4'd5));
                b.regsWr.gprWr = 1'b1;
                b.dstSel = DST_RT;
            end else begin
                b.storeType = storeTypeT'(2'(1 + r[7:4] % 4'd3));
            end
            if (r[10:8] == 3'd0) b.exceptIn = EXC_SYSCALL;
            runInstr(b, r[12:11] == 2'd0);
        end

        // abort a divide and then suppress a multiply, a load and an MTHI
        b = makeBase();
        b.aluOp = OP_DIV;
        flushDivide(b);
        readBack();
        b = makeBase();
        b.aluOp = OP_MULT;
        runInstr(b, 1'b1);
        readBack();
        b = makeBase();
        b.aluOp = OP_ADDU;
        b.loadType = LD_LW;
        b.regsWr.gprWr = 1'b1;
        runInstr(b, 1'b1);
        b = makeBase();
        b.aluOp = OP_MTHI;
        b.regsWr.hiWr = 1'b1;
        runInstr(b, 1'b1);
        readBack();

        @(posedge clk);
        doCheck = 1'b0;
        $display("Test passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/exePkg.sv
hw/exeReg.sv
hw/alu.sv
hw/branchSolve.sv
hw/multDiv.sv
hw/hiLo.sv
hw/exceptInExe.sv
hw/topExe.sv
verif/tbTopExe.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tbTopExe \
    -Mdir obj_dir -o simTopExe
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simTopExe
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
